/* Makefile */
# Verilator build and run for the mesh router testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mesh_router
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAIL
PASS_MSG  := TEST PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result found in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/mesh_router.sv */
// Five-link mesh router: local, north, east, south, west.
// All per-link ports are packed by noc_pkg::port_e index.
// Input to output latency is at least two cycles, more under contention.

`timescale 1ns/100ps
`default_nettype none

module mesh_router (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire noc_pkg::xy_t   xy_id_i,
  input  wire logic           [noc_pkg::num_ports-1:0] in_valid_i,
  input  wire noc_pkg::flit_t [noc_pkg::num_ports-1:0] in_flit_i,
  output logic                [noc_pkg::num_ports-1:0] in_ready_o,
  output logic                [noc_pkg::num_ports-1:0] out_valid_o,
  output noc_pkg::flit_t      [noc_pkg::num_ports-1:0] out_flit_o,
  input  wire logic           [noc_pkg::num_ports-1:0] out_ready_i
);

  // Row index is the input port for in_*, the output port for out_*
  noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] in_req;
  noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] in_grant;
  noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] out_req;
  noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] out_grant;
  noc_pkg::flit_t      [noc_pkg::num_ports-1:0] head_flit;

  // Transpose requests and grants between the two sides
  for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : gen_xpose_row
    for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : gen_xpose_col
      assign out_req[o][i]  = in_req[i][o];
      assign in_grant[i][o] = out_grant[o][i];
    end
  end

  for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : gen_in_port
    router_input_port i_input_port (
      .clk_i       ( clk_i         ),
      .rst_n_i     ( rst_n_i       ),
      .xy_id_i     ( xy_id_i       ),
      .in_valid_i  ( in_valid_i[i] ),
      .in_flit_i   ( in_flit_i[i]  ),
      .in_ready_o  ( in_ready_o[i] ),
      .req_o       ( in_req[i]     ),
      .head_flit_o ( head_flit[i]  ),
      .grant_i     ( in_grant[i]   )
    );
  end

  // Every arbiter sees all head flits and picks by its own grant
  for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : gen_out_arb
    router_output_arb i_output_arb (
      .clk_i       ( clk_i          ),
      .rst_n_i     ( rst_n_i        ),
      .req_i       ( out_req[o]     ),
      .flits_i     ( head_flit      ),
      .grant_o     ( out_grant[o]   ),
      .out_valid_o ( out_valid_o[o] ),
      .out_flit_o  ( out_flit_o[o]  ),
      .out_ready_i ( out_ready_i[o] )
    );
  end

endmodule

`default_nettype wire

/* source/noc_pkg.sv */
// Shared definitions for the single mesh router.
// Coordinates are 2 bits per axis, so the mesh is at most 4 by 4.
// port_e values double as the index of each link in packed port arrays.

`default_nettype none

package noc_pkg;

  // Coordinate and payload sizes
  localparam int unsigned coord_w   = 2;
  localparam int unsigned payload_w = 16;

  // Link count and the width of a port index
  localparam int unsigned num_ports = 5;
  localparam int unsigned port_w    = 3;

  // Input buffering
  localparam int unsigned fifo_depth = 4;
  localparam int unsigned fifo_ptr_w = $clog2(fifo_depth);
  localparam int unsigned fifo_cnt_w = $clog2(fifo_depth + 1);

  // Link directions, also used as the port index
  typedef enum logic [port_w-1:0] {
    port_local = 3'd0,
    port_north = 3'd1,
    port_east  = 3'd2,
    port_south = 3'd3,
    port_west  = 3'd4
  } port_e;

  // Node or destination coordinate, x in the upper bits
  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } xy_t;

  // One-flit packet: destination first, then payload
  typedef struct packed {
    xy_t                  dest;
    logic [payload_w-1:0] payload;
  } flit_t;

  // One bit per link, for route requests and grants
  typedef logic [num_ports-1:0] port_mask_t;

endpackage

`default_nettype wire

/* source/router_in_fifo.sv */
// Input flit buffer with valid/ready on both sides.
// The pop side has no ready check of its own: pop_i must only be raised
// while head_valid_o is high. A pushed flit reaches the head a cycle later.

`timescale 1ns/100ps
`default_nettype none

module router_in_fifo (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           push_valid_i,
  input  wire noc_pkg::flit_t push_flit_i,
  output logic                push_ready_o,
  input  wire logic           pop_i,
  output logic                head_valid_o,
  output noc_pkg::flit_t      head_flit_o
);

  noc_pkg::flit_t                     mem [noc_pkg::fifo_depth];
  logic [noc_pkg::fifo_ptr_w-1:0]     wr_ptr;
  logic [noc_pkg::fifo_ptr_w-1:0]     rd_ptr;
  logic [noc_pkg::fifo_cnt_w-1:0]     count;
  logic                               push_fire;

  assign push_ready_o = (count != noc_pkg::fifo_cnt_w'(noc_pkg::fifo_depth));
  assign head_valid_o = (count != '0);
  assign head_flit_o  = mem[rd_ptr];
  assign push_fire    = push_valid_i && push_ready_o;

  // Pointers wrap at the last entry, so any depth works
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        if (wr_ptr == noc_pkg::fifo_ptr_w'(noc_pkg::fifo_depth - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr == noc_pkg::fifo_ptr_w'(noc_pkg::fifo_depth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({push_fire, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_flit_i;
    end
  end

  // A grant from an output arbiter must only reach a port with a head flit
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> head_valid_o)
    else $error("input FIFO popped while empty");

  // While full, the upstream node keeps its flit, so nothing is dropped
  a_hold_while_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_flit_i))
    else $error("flit withdrawn by upstream while FIFO full");

endmodule

`default_nettype wire

/* source/router_input_port.sv */
// One input link: flit FIFO plus the XY route decision for its head.
// The request is combinational from the FIFO head and adds no cycles.
// A flit for this node arriving on the local link requests local again.

`timescale 1ns/100ps
`default_nettype none

module router_input_port (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire noc_pkg::xy_t        xy_id_i,
  input  wire logic                in_valid_i,
  input  wire noc_pkg::flit_t      in_flit_i,
  output logic                     in_ready_o,
  output noc_pkg::port_mask_t      req_o,
  output noc_pkg::flit_t           head_flit_o,
  input  wire noc_pkg::port_mask_t grant_i
);

  logic            head_valid;
  logic            pop;
  noc_pkg::port_e  route_dir;

  // Any arbiter taking the head flit pops it
  assign pop = |grant_i;

  router_in_fifo i_in_fifo (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .push_valid_i ( in_valid_i   ),
    .push_flit_i  ( in_flit_i    ),
    .push_ready_o ( in_ready_o   ),
    .pop_i        ( pop          ),
    .head_valid_o ( head_valid   ),
    .head_flit_o  ( head_flit_o  )
  );

  // X first, then Y, then deliver locally
  always_comb begin
    if (head_flit_o.dest.x > xy_id_i.x) begin
      route_dir = noc_pkg::port_east;
    end else if (head_flit_o.dest.x < xy_id_i.x) begin
      route_dir = noc_pkg::port_west;
    end else if (head_flit_o.dest.y > xy_id_i.y) begin
      route_dir = noc_pkg::port_north;
    end else if (head_flit_o.dest.y < xy_id_i.y) begin
      route_dir = noc_pkg::port_south;
    end else begin
      route_dir = noc_pkg::port_local;
    end
  end

  assign req_o = head_valid ? (noc_pkg::port_mask_t'(1) << route_dir) : '0;

  // Only the one requested arbiter may answer, and at most one at a time
  a_grant_matches_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_i) && ((grant_i & ~req_o) == '0))
    else $error("grant not matching the route request");

endmodule

`default_nettype wire

/* source/router_output_arb.sv */
// One output link: round-robin choice among the requesting inputs and a
// single output register. A grant is given only when that register is
// empty or drains this cycle; the granted flit shows one cycle later.

`timescale 1ns/100ps
`default_nettype none

module router_output_arb (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire noc_pkg::port_mask_t req_i,
  input  wire noc_pkg::flit_t      [noc_pkg::num_ports-1:0] flits_i,
  output noc_pkg::port_mask_t      grant_o,
  output logic                     out_valid_o,
  output noc_pkg::flit_t           out_flit_o,
  input  wire logic                out_ready_i
);

  logic [noc_pkg::port_w-1:0] rr_ptr;
  logic [noc_pkg::port_w-1:0] sel_idx;
  logic [noc_pkg::port_w-1:0] next_ptr;
  logic                       sel_found;
  logic                       can_load;
  logic                       grant_any;
  logic                       out_valid_q;
  noc_pkg::flit_t             out_flit_q;

  // Register is free, or its flit leaves on this edge
  assign can_load = !out_valid_q || out_ready_i;

  // Search starts at rr_ptr and wraps around all ports
  always_comb begin : rr_search
    int unsigned idx;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int unsigned i = 0; i < noc_pkg::num_ports; i++) begin
      idx = int'(rr_ptr) + i;
      if (idx >= noc_pkg::num_ports) begin
        idx = idx - noc_pkg::num_ports;
      end
      if (!sel_found && req_i[idx]) begin
        sel_found = 1'b1;
        sel_idx   = noc_pkg::port_w'(idx);
      end
    end
  end

  assign grant_any = sel_found && can_load;
  assign grant_o   = grant_any ? (noc_pkg::port_mask_t'(1) << sel_idx) : '0;

  // Port after the granted one gets first look next time
  always_comb begin
    if (sel_idx == noc_pkg::port_w'(noc_pkg::num_ports - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = sel_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (grant_any) begin
        rr_ptr      <= next_ptr;
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_any) begin
      out_flit_q <= flits_i[sel_idx];
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

  // Downstream back-pressure must freeze the offered flit
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_flit_o))
    else $error("output flit changed while stalled");

endmodule

`default_nettype wire

/* tb.f */
source/noc_pkg.sv
source/router_in_fifo.sv
source/router_input_port.sv
source/router_output_arb.sv
source/mesh_router.sv
verif/tb_mesh_router.sv

/* verif/router_stimulus.txt */
// First word: node coordinate in the low hex digit, x in its upper 2 bits
// Then per flit: group, input port, destination, payload (4 digits), expected output
// Groups: 0 random traffic, 1 stall west to east, 2 round robin to local
00000006
00A00012
00700021
01420013
01620020
02240014
02740021
03760011
03660020
04F80012
04580023
00600030
02540033
04A80032
00000044
14B81012
14B81022
14B81032
14B81042
14B81052
14B81062
14B81072
21622010
23662010
21622020
23662020
21622030
23662030
21622040
23662040
FFFFFFFF

/* verif/tb_mesh_router.sv */
// Testbench for the mesh router, run from the project root so that
// verif/router_stimulus.txt is found. The top 3 payload bits of every
// stimulus flit must hold its source port index, since the checker
// matches arriving flits to their input by those bits.

`timescale 1ns/100ps
`default_nettype none

module tb_mesh_router;

  logic                                         clk = 1'b0;
  logic                                         rst_n;
  noc_pkg::xy_t                                 xy_id;
  logic           [noc_pkg::num_ports-1:0]      in_valid;
  noc_pkg::flit_t [noc_pkg::num_ports-1:0]      in_flit;
  logic           [noc_pkg::num_ports-1:0]      in_ready;
  logic           [noc_pkg::num_ports-1:0]      out_valid;
  noc_pkg::flit_t [noc_pkg::num_ports-1:0]      out_flit;
  logic           [noc_pkg::num_ports-1:0]      out_ready;

  logic [31:0]                   stim [64];
  int                            num_flits = 0;
  int                            limit_cycles = 0;
  int                            err_cnt = 0;
  int                            fault_cnt = 0;
  string                         test_name = "reset";
  int                            idle_pct = 0;
  int                            stall_pct = 0;
  logic [noc_pkg::num_ports-1:0] hold_low = '0;
  logic [noc_pkg::num_ports-1:0] took = '0;
  int                            acc_cnt [noc_pkg::num_ports] = '{default: 0};
  noc_pkg::flit_t                src_q [noc_pkg::num_ports][$];
  int                            src_e_q [noc_pkg::num_ports][$];
  noc_pkg::flit_t                exp_q [noc_pkg::num_ports][noc_pkg::num_ports][$];
  logic                          rr_on = 1'b0;
  logic                          rr_seen = 1'b0;
  noc_pkg::port_e                rr_prev = noc_pkg::port_local;
  // Group 2 of the stimulus sends from north and south to local
  noc_pkg::port_e                rr_a = noc_pkg::port_north;
  noc_pkg::port_e                rr_b = noc_pkg::port_south;
  noc_pkg::port_e                rr_out = noc_pkg::port_local;

  always #2 clk = ~clk;

  mesh_router UUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .xy_id_i     ( xy_id     ),
    .in_valid_i  ( in_valid  ),
    .in_flit_i   ( in_flit   ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .out_flit_o  ( out_flit  ),
    .out_ready_i ( out_ready )
  );

  task automatic check_flit(input string name, input noc_pkg::flit_t exp,
                            input noc_pkg::flit_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_port(input string name, input noc_pkg::port_e exp,
                            input noc_pkg::port_e act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Flits not yet sent plus flits sent but not yet seen at an output
  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      n += src_q[p].size();
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
        n += exp_q[p][o].size();
      end
    end
    return n;
  endfunction

  // Word layout: group, input port, destination, payload, expected output
  task automatic queue_group(input logic [3:0] grp);
    logic [31:0] w;
    for (int k = 1; k <= num_flits; k++) begin
      w = stim[k];
      if (w[31:28] == grp) begin
        src_q[int'(w[27:24])].push_back(noc_pkg::flit_t'(w[23:4]));
        src_e_q[int'(w[27:24])].push_back(int'(w[3:0]));
      end
    end
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (pending() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic take_output(input int o, input noc_pkg::flit_t f);
    int             s;
    int             e;
    noc_pkg::port_e alt;
    s = int'(f.payload[noc_pkg::payload_w-1 -: noc_pkg::port_w]);
    if (s >= int'(noc_pkg::num_ports)) begin
      fault_cnt++;
      $display("Flit %h on output %0d carries no valid source port", f, o);
      return;
    end
    if (rr_on && o == int'(rr_out)) begin
      alt = (rr_prev == rr_a) ? rr_b : rr_a;
      if (rr_seen && exp_q[int'(alt)][o].size() != 0) begin
        check_port("round_robin_source", alt, noc_pkg::port_e'(s));
      end
      rr_prev = noc_pkg::port_e'(s);
      rr_seen = 1'b1;
    end
    if (exp_q[s][o].size() != 0) begin
      check_flit({test_name, "_flit"}, exp_q[s][o].pop_front(), f);
    end else begin
      // Nothing due here, so blame the route of the oldest pending flit
      e = -1;
      for (int k = 0; k < noc_pkg::num_ports; k++) begin
        if (e < 0 && exp_q[s][k].size() != 0) begin
          e = k;
        end
      end
      if (e >= 0) begin
        check_port({test_name, "_route"}, noc_pkg::port_e'(e), noc_pkg::port_e'(o));
        void'(exp_q[s][e].pop_front());
      end else begin
        fault_cnt++;
        $display("Flit %h left on output %0d although input %0d had nothing outstanding",
                 f, o, s);
      end
    end
  endtask

  // Handshakes are taken at the rising edge, where all link signals are steady
  always @(posedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < noc_pkg::num_ports; p++) begin
        took[p] = in_valid[p] && in_ready[p];
        if (took[p]) begin
          acc_cnt[p]++;
        end
        if (out_valid[p] && out_ready[p]) begin
          take_output(p, out_flit[p]);
        end
      end
    end
  end

  // Upstream and downstream models, driven on the falling edge
  initial begin : driver
    noc_pkg::flit_t f;
    int             e;
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '0;
    forever begin
      @(negedge clk);
      for (int p = 0; p < noc_pkg::num_ports; p++) begin
        if (!in_valid[p] || took[p]) begin
          if (src_q[p].size() != 0 && $urandom_range(99) >= idle_pct) begin
            f = src_q[p].pop_front();
            e = src_e_q[p].pop_front();
            exp_q[p][e].push_back(f);
            in_valid[p] = 1'b1;
            in_flit[p]  = f;
          end else begin
            in_valid[p] = 1'b0;
          end
        end
        out_ready[p] = !hold_low[p] && ($urandom_range(99) >= stall_pct);
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, %0d flits were never delivered",
             limit_cycles, pending());
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int             base;
    noc_pkg::flit_t held;
    void'($urandom(79028));
    rst_n = 1'b0;
    for (int k = 0; k < 64; k++) begin
      stim[k] = '1;
    end
    $readmemh("verif/router_stimulus.txt", stim);
    while (num_flits < 63 && stim[num_flits + 1] != '1) begin
      num_flits++;
    end
    if (num_flits == 0) begin
      fault_cnt++;
      $display("Stimulus file is missing or holds no flits");
    end
    xy_id = noc_pkg::xy_t'(stim[0][3:0]);
    limit_cycles = 40 * num_flits + 200;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int p = 0; p < noc_pkg::num_ports; p++) begin
      check_bit("reset_in_ready", 1'b1, in_ready[p]);
      check_bit("reset_out_valid", 1'b0, out_valid[p]);
    end

    @(posedge clk);
    test_name = "xy_random";
    idle_pct  = 30;
    stall_pct = 40;
    queue_group(4'h0);
    wait_drained();

    // West to east with east held off, so the west FIFO must fill
    @(posedge clk);
    test_name = "stall";
    idle_pct  = 0;
    stall_pct = 0;
    hold_low[noc_pkg::port_east] = 1'b1;
    base = acc_cnt[noc_pkg::port_west];
    queue_group(4'h1);
    @(negedge clk);
    while (in_ready[noc_pkg::port_west]) begin
      @(negedge clk);
    end
    if (acc_cnt[noc_pkg::port_west] - base > int'(noc_pkg::fifo_depth) + 1) begin
      fault_cnt++;
      $display("West input took %0d flits for a stalled output, more than it can buffer",
               acc_cnt[noc_pkg::port_west] - base);
    end
    // First stall flit sits in the east output register until ready returns
    held = exp_q[noc_pkg::port_west][noc_pkg::port_east][0];
    check_bit("stall_out_valid", 1'b1, out_valid[noc_pkg::port_east]);
    repeat (6) begin
      @(negedge clk);
      check_flit("stall_hold", held, out_flit[noc_pkg::port_east]);
      check_bit("stall_in_ready", 1'b0, in_ready[noc_pkg::port_west]);
    end
    @(posedge clk);
    hold_low = '0;
    wait_drained();
    check_bit("stall_recover", 1'b1, in_ready[noc_pkg::port_west]);

    @(posedge clk);
    test_name = "round_robin";
    rr_seen   = 1'b0;
    rr_on     = 1'b1;
    queue_group(4'h2);
    wait_drained();
    rr_on = 1'b0;

    $display("Run complete with %0d value errors and %0d other failures",
             err_cnt, fault_cnt);
    if (err_cnt == 0 && fault_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
